/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing -f vlog.f --top-module tb_decode_top -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_decode_top 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* dv/decode_tests.txt */
# W rd data | S stall_cycles | H trailing_instr   (all values hex)
# I instr fu_t fu_s fu_m alu_op branch_op s_mem m_mem matrix_rd imm rs1_val rs2_val stride_val
W 01 00000010
W 02 fffffff0
W 03 00001234
W 04 80000000
W 05 11111111
W 00 deadbeef
I 00208333 0 1 0 0 0 0 0 0 00000000 00000010 fffffff0 00000000
I 401183b3 0 1 0 1 0 0 0 0 00000000 00001234 00000010 00000000
I 40225433 0 1 0 4 0 0 0 0 00000000 80000000 fffffff0 00000000
I 003034b3 0 1 0 9 0 0 0 0 00000000 00000000 00001234 00000000
I ffd08513 0 1 0 0 0 0 0 0 fffffffd 00000010 00000000 00000000
I 40425593 0 1 0 4 0 0 0 0 00000404 80000000 00000000 00000000
I 7ff14613 0 1 0 7 0 0 0 0 000007ff fffffff0 00000000 00000000
I ff81a683 0 2 0 0 0 1 0 0 fffffff8 00001234 00000000 00000000
I 8a20a2a3 0 2 0 0 0 2 0 0 fffff8a5 00000010 fffffff0 00000000
I a4209ae3 0 3 0 0 2 0 0 0 fffffa54 00000010 fffffff0 00000000
I 0001f863 0 3 0 0 6 0 0 0 00000010 00001234 00000000 00000000
I a5ba50ef 0 1 0 0 0 0 0 0 fffa5a5a 00000000 00000000 00000000
I 00c082e7 0 1 0 0 0 0 0 0 0000000c 00000010 00000000 00000000
I 308ff80b 1 0 1 0 0 0 1 3 fffffff0 00000010 00000000 00001234
I 920891ab 1 0 1 0 0 0 2 9 00000123 80000000 00000000 fffffff0
I f1234d5b 2 0 2 0 0 0 0 f 00000000 00000000 00000000 00000000
I 00000077 0 0 0 0 0 0 0 0 00000000 00000000 00000000 00000000
W 05 0000abcd
I 00528733 0 1 0 0 0 0 0 0 00000000 0000abcd 0000abcd 00000000
W 03 cafef00d
I 228c000b 1 0 1 0 0 0 1 2 00000000 0000abcd 00000000 cafef00d
S 3
I 0020c7b3 0 1 0 7 0 0 0 0 00000000 00000010 fffffff0 00000000
H 00208333

/* dv/tb_decode_top.sv */
////////////////////////////////////////////////////////////
// testbench for decode_top, driven by records from the tests file
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top
    import isa_pkg::*;
();

    localparam int HALF_PERIOD = 4;
    localparam int MAX_RECS    = 64;
    localparam int NF          = 13;
    localparam int TRAIL_CYCLES = 6;
    localparam logic [31:0] HALT_WORD = 32'h0000007f;

    logic      clk = 1'b0;
    logic      rst;
    word_t     instr;
    logic      instr_valid;
    logic      stall;
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;
    issue_t    issue;
    logic      issue_valid;
    logic      halted;

    // parsed records: kind letter plus up to NF hex fields
    logic [7:0]  rec_kind [MAX_RECS];
    logic [31:0] rec_f [MAX_RECS][NF];
    int num_recs   = 0;
    int num_checks = 0;
    int cycles     = 0;
    int limit      = 50;
    int stall_n    = 0;

    decode_top #(
        .NUM_SREGS (32)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .stall       (stall),
        .wb_en       (wb_en),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .issue       (issue),
        .issue_valid (issue_valid),
        .halted      (halted)
    );

    always #HALF_PERIOD clk = ~clk;

    // run limit scales with the number of records
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= limit)
        begin
            $display("timeout: run went past %0d cycles without finishing", limit);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        num_checks = num_checks + 1;
        if (got !== exp)
        begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic read_tests;
        int                fd;
        int                code;
        int                nf;
        logic              done;
        logic [8*16-1:0]   tok;
        logic [8*256-1:0]  rest;
        logic [7:0]        kind;
        logic [31:0]       val;
        fd = $fopen("dv/decode_tests.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the tests file dv/decode_tests.txt");
            $display("SIMULATION FAILED");
            $fatal(1, "missing tests file");
        end
        done = 1'b0;
        while (!done)
        begin
            code = $fscanf(fd, "%s", tok);
            kind = tok[7:0];
            if (code != 1)
            begin
                done = 1'b1;
            end
            else if (kind == "#")
            begin
                code = $fgets(rest, fd);
            end
            else
            begin
                case (kind)
                    "W": nf = 2;
                    "I": nf = NF;
                    "S": nf = 1;
                    "H": nf = 1;
                    default: nf = 0;
                endcase
                if (nf == 0 || num_recs == MAX_RECS)
                begin
                    $display("bad or too many records in the tests file at record %0d", num_recs);
                    $display("SIMULATION FAILED");
                    $fatal(1, "bad tests file");
                end
                for (int k = 0; k < nf; k++)
                begin
                    code = $fscanf(fd, "%h", val);
                    if (code != 1)
                    begin
                        $display("record %0d in the tests file is cut short", num_recs);
                        $display("SIMULATION FAILED");
                        $fatal(1, "truncated record");
                    end
                    rec_f[num_recs][k] = val;
                end
                rec_kind[num_recs] = kind;
                num_recs = num_recs + 1;
            end
        end
        $fclose(fd);
    endtask

    // a write left pending gets its own cycle
    task automatic flush_write;
        if (wb_en)
        begin
            @(posedge clk);
            @(negedge clk);
            wb_en = 1'b0;
        end
    endtask

    task automatic compare_issue(input int r);
        check("fu_t", 32'(issue.ctrl.fu_t), rec_f[r][1]);
        check("fu_s", 32'(issue.ctrl.fu_s), rec_f[r][2]);
        check("fu_m", 32'(issue.ctrl.fu_m), rec_f[r][3]);
        check("alu_op", 32'(issue.ctrl.alu_op), rec_f[r][4]);
        check("branch_op", 32'(issue.ctrl.branch_op), rec_f[r][5]);
        check("s_mem_type", 32'(issue.ctrl.s_mem_type), rec_f[r][6]);
        check("m_mem_type", 32'(issue.ctrl.m_mem_type), rec_f[r][7]);
        check("matrix_rd", 32'(issue.ctrl.matrix_rd), rec_f[r][8]);
        check("imm", issue.ctrl.imm, rec_f[r][9]);
        check("rs1_val", issue.rs1_val, rec_f[r][10]);
        check("rs2_val", issue.rs2_val, rec_f[r][11]);
        check("stride_val", issue.stride_val, rec_f[r][12]);
    endtask

    task automatic run_instr(input int r, input int n_stall, input logic drop_check);
        issue_t held;
        logic   held_valid;
        held        = issue;
        held_valid  = issue_valid;
        instr       = rec_f[r][0];
        instr_valid = 1'b1;
        if (n_stall > 0)
        begin
            stall = 1'b1;
            repeat (n_stall)
            begin
                @(posedge clk);
                @(negedge clk);
                wb_en = 1'b0;
                check("issue held under stall", 32'(issue == held), 1);
                check("issue_valid under stall", 32'(issue_valid), 32'(held_valid));
            end
            stall = 1'b0;
        end
        @(posedge clk);
        @(negedge clk);
        wb_en       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        check("issue_valid", 32'(issue_valid), 1);
        compare_issue(r);
        // valid is a one-cycle pulse
        if (drop_check)
        begin
            @(posedge clk);
            @(negedge clk);
            check("issue_valid after pulse", 32'(issue_valid), 0);
        end
    endtask

    task automatic run_halt(input int r);
        instr       = HALT_WORD;
        instr_valid = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check("issue_valid for halt", 32'(issue_valid), 1);
        check("ctrl.halt", 32'(issue.ctrl.halt), 1);
        check("halted", 32'(halted), 1);
        // trailing instruction stays offered and must be ignored
        instr = rec_f[r][0];
        repeat (TRAIL_CYCLES)
        begin
            @(posedge clk);
            @(negedge clk);
            check("issue_valid after halt", 32'(issue_valid), 0);
            check("halted stays set", 32'(halted), 1);
        end
        instr_valid = 1'b0;
    endtask

    initial
    begin
        rst         = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        stall       = 1'b0;
        wb_en       = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        read_tests();
        limit = 20 * num_recs + 50;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check("issue_valid after reset", 32'(issue_valid), 0);
        check("halted after reset", 32'(halted), 0);
        check("issue clear after reset", 32'(issue == '0), 1);

        for (int r = 0; r < num_recs; r++)
        begin
            case (rec_kind[r])
                "W":
                begin
                    flush_write();
                    wb_en   = 1'b1;
                    wb_rd   = rec_f[r][0][4:0];
                    wb_data = rec_f[r][1];
                end
                "I":
                begin
                    run_instr(r, stall_n, !((r + 1 < num_recs) && rec_kind[r + 1] == "S"));
                    stall_n = 0;
                end
                "S":
                begin
                    flush_write();
                    stall_n = rec_f[r][0];
                end
                default:
                begin
                    flush_write();
                    run_halt(r);
                end
            endcase
        end
        flush_write();

        if (num_checks > 0)
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
        else
        begin
            $display("no checks ran, the tests file holds no records");
            $display("SIMULATION FAILED");
            $fatal(1, "empty test");
        end
    end

endmodule

`default_nettype wire

/* hw/control_unit.sv */
////////////////////////////////////////////////////////////
// instruction decoder producing the control word and immediate
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module control_unit
    import isa_pkg::*;
(
    input  word_t instr,
    output ctrl_t ctrl
);

    instr_u  iw;
    opcode_t op;
    logic    alt;
    logic    legal;
    word_t   i_imm;
    word_t   s_imm;
    word_t   b_imm;
    word_t   j_imm;
    word_t   m_imm;

    assign iw  = instr;
    assign op  = opcode_t'(iw.r_fmt.opcode);
    assign alt = (iw.r_fmt.funct7 == F7_ALT);

    // sign-extended immediates, one per format
    assign i_imm = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
    assign s_imm = {{20{iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};
    assign b_imm = {{19{iw.b_fmt.imm_12}}, iw.b_fmt.imm_12, iw.b_fmt.imm_11,
                    iw.b_fmt.imm_10_5, iw.b_fmt.imm_4_1, 1'b0};
    // no J layout in the union, so taken from the raw word
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};
    assign m_imm = {{21{iw.m_fmt.offset[10]}}, iw.m_fmt.offset};

    // sub only exists in the register form, sra in both
    function automatic aluop_t alu_decode(
        input logic [2:0] f3,
        input logic       alt_bit,
        input logic       sub_en
    );
        aluop_t op_out;
        case (f3)
            F3_ADD_SUB: op_out = (alt_bit && sub_en) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op_out = ALU_SLL;
            F3_SLT:     op_out = ALU_SLT;
            F3_SLTU:    op_out = ALU_SLTU;
            F3_XOR:     op_out = ALU_XOR;
            F3_SRL_SRA: op_out = alt_bit ? ALU_SRA : ALU_SRL;
            F3_OR:      op_out = ALU_OR;
            default:    op_out = ALU_AND;
        endcase
        return op_out;
    endfunction

    always_comb
    begin
        ctrl  = '0;
        legal = 1'b1;
        case (op)
            RTYPE:
            begin
                ctrl.s_reg_write = 1'b1;
                ctrl.fu_s        = FU_S_ALU;
                ctrl.alu_op      = alu_decode(iw.r_fmt.funct3, alt, 1'b1);
                ctrl.rd          = iw.r_fmt.rd;
                ctrl.rs1         = iw.r_fmt.rs1;
                ctrl.rs2         = iw.r_fmt.rs2;
            end
            ITYPE:
            begin
                ctrl.s_reg_write = 1'b1;
                ctrl.i_flag      = 1'b1;
                ctrl.fu_s        = FU_S_ALU;
                ctrl.alu_op      = alu_decode(iw.i_fmt.funct3, alt, 1'b0);
                ctrl.imm         = i_imm;
                ctrl.rd          = iw.i_fmt.rd;
                ctrl.rs1         = iw.i_fmt.rs1;
            end
            ITYPE_LW:
            begin
                legal            = (iw.i_fmt.funct3 == F3_WORD);
                ctrl.s_reg_write = 1'b1;
                ctrl.i_flag      = 1'b1;
                ctrl.s_mem_type  = LOAD;
                ctrl.fu_s        = FU_S_LD_ST;
                ctrl.imm         = i_imm;
                ctrl.rd          = iw.i_fmt.rd;
                ctrl.rs1         = iw.i_fmt.rs1;
            end
            STYPE:
            begin
                legal           = (iw.s_fmt.funct3 == F3_WORD);
                ctrl.i_flag     = 1'b1;
                ctrl.s_mem_type = STORE;
                ctrl.fu_s       = FU_S_LD_ST;
                ctrl.imm        = s_imm;
                ctrl.rs1        = iw.s_fmt.rs1;
                ctrl.rs2        = iw.s_fmt.rs2;
            end
            BTYPE:
            begin
                ctrl.fu_s = FU_S_BRANCH;
                ctrl.imm  = b_imm;
                ctrl.rs1  = iw.b_fmt.rs1;
                ctrl.rs2  = iw.b_fmt.rs2;
                case (iw.b_fmt.funct3)
                    F3_BEQ:  ctrl.branch_op = BT_BEQ;
                    F3_BNE:  ctrl.branch_op = BT_BNE;
                    F3_BLT:  ctrl.branch_op = BT_BLT;
                    F3_BGE:  ctrl.branch_op = BT_BGE;
                    F3_BLTU: ctrl.branch_op = BT_BLTU;
                    F3_BGEU: ctrl.branch_op = BT_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            JAL:
            begin
                ctrl.jal         = 1'b1;
                ctrl.s_reg_write = 1'b1;
                ctrl.i_flag      = 1'b1;
                ctrl.alu_op      = ALU_ADD;
                ctrl.fu_s        = FU_S_ALU;
                ctrl.imm         = j_imm;
                ctrl.rd          = iw.r_fmt.rd;
            end
            JALR:
            begin
                ctrl.jalr        = 1'b1;
                ctrl.s_reg_write = 1'b1;
                ctrl.i_flag      = 1'b1;
                ctrl.alu_op      = ALU_ADD;
                ctrl.fu_s        = FU_S_ALU;
                ctrl.imm         = i_imm;
                ctrl.rd          = iw.i_fmt.rd;
                ctrl.rs1         = iw.i_fmt.rs1;
            end
            HALT:
            begin
                ctrl.halt = 1'b1;
            end
            LD_M, ST_M:
            begin
                // base + offset, rows spaced by the stride register
                ctrl.fu_m        = FU_M_LD_ST;
                ctrl.fu_t        = FU_M_T;
                ctrl.m_mem_type  = (op == LD_M) ? M_LOAD : M_STORE;
                ctrl.m_reg_write = (op == LD_M);
                ctrl.matrix_rd   = iw.m_fmt.matrix_rd;
                ctrl.rs1         = iw.m_fmt.rs1;
                ctrl.stride      = iw.m_fmt.stride;
                ctrl.imm         = m_imm;
            end
            GEMM:
            begin
                ctrl.fu_m        = FU_M_GEMM;
                ctrl.fu_t        = FU_G_T;
                ctrl.m_reg_write = 1'b1;
                ctrl.matrix_rd   = iw.m_fmt.matrix_rd;
            end
            default:
            begin
                legal = 1'b0;
            end
        endcase

        // anything unrecognised issues as a no-op
        if (!legal)
        begin
            ctrl = '0;
        end
    end

endmodule

`default_nettype wire

/* hw/decode_top.sv */
////////////////////////////////////////////////////////////
// decode and issue front end: decoder, regfile, issue slot
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_top
    import isa_pkg::*;
#(
    parameter int NUM_SREGS = 32
)
(
    input  logic      clk,
    input  logic      rst,
    input  word_t     instr,
    input  logic      instr_valid,
    input  logic      stall,
    input  logic      wb_en,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    output issue_t    issue,
    output logic      issue_valid,
    output logic      halted
);

    ctrl_t ctrl;
    word_t rs1_data;
    word_t rs2_data;
    word_t rs3_data;

    control_unit u_control_unit (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // decoded register fields address the file directly
    scalar_regfile #(
        .NUM_SREGS (NUM_SREGS)
    ) u_scalar_regfile (
        .clk      (clk),
        .rst      (rst),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1      (ctrl.rs1),
        .rs2      (ctrl.rs2),
        .rs3      (ctrl.stride),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs3_data (rs3_data)
    );

    issue_stage u_issue_stage (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .stall       (stall),
        .ctrl        (ctrl),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs3_data    (rs3_data),
        .issue       (issue),
        .issue_valid (issue_valid),
        .halted      (halted)
    );

endmodule

`default_nettype wire

/* hw/isa_pkg.sv */
////////////////////////////////////////////////////////////
// opcodes, funct3 codes and decode enums
// instruction format union, control word and issue slot structs
////////////////////////////////////////////////////////////
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  mreg_addr_t;

    // base opcodes, matrix ops live in the custom space
    typedef enum logic [6:0] {
        RTYPE    = 7'b0110011,
        ITYPE    = 7'b0010011,
        ITYPE_LW = 7'b0000011,
        STYPE    = 7'b0100011,
        BTYPE    = 7'b1100011,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        HALT     = 7'b1111111,
        LD_M     = 7'b0001011,
        ST_M     = 7'b0101011,
        GEMM     = 7'b1011011
    } opcode_t;

    // alu funct3, shared by register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'h0;
    localparam logic [2:0] F3_SLL     = 3'h1;
    localparam logic [2:0] F3_SLT     = 3'h2;
    localparam logic [2:0] F3_SLTU    = 3'h3;
    localparam logic [2:0] F3_XOR     = 3'h4;
    localparam logic [2:0] F3_SRL_SRA = 3'h5;
    localparam logic [2:0] F3_OR      = 3'h6;
    localparam logic [2:0] F3_AND     = 3'h7;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'h0;
    localparam logic [2:0] F3_BNE  = 3'h1;
    localparam logic [2:0] F3_BLT  = 3'h4;
    localparam logic [2:0] F3_BGE  = 3'h5;
    localparam logic [2:0] F3_BLTU = 3'h6;
    localparam logic [2:0] F3_BGEU = 3'h7;

    // only word-sized scalar loads and stores
    localparam logic [2:0] F3_WORD = 3'h2;

    // funct7 that turns add into sub and srl into sra
    localparam logic [6:0] F7_ALT = 7'h20;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU
    } aluop_t;

    typedef enum logic [2:0] {
        BT_NONE,
        BT_BEQ,
        BT_BNE,
        BT_BLT,
        BT_BGE,
        BT_BLTU,
        BT_BGEU
    } branch_t;

    typedef enum logic [1:0] {
        S_MEM_NONE,
        LOAD,
        STORE
    } scalar_mem_t;

    typedef enum logic [1:0] {
        M_MEM_NONE,
        M_LOAD,
        M_STORE
    } matrix_mem_t;

    typedef enum logic [1:0] {
        FU_S_NONE,
        FU_S_ALU,
        FU_S_LD_ST,
        FU_S_BRANCH
    } fu_scalar_t;

    typedef enum logic [1:0] {
        FU_M_NONE,
        FU_M_LD_ST,
        FU_M_GEMM
    } fu_matrix_t;

    // target class: scalar, matrix memory, gemm
    typedef enum logic [1:0] {
        FU_S_T,
        FU_M_T,
        FU_G_T
    } fu_type_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    // matrix memory layout, rs1 holds the scalar base address
    typedef struct packed {
        mreg_addr_t  matrix_rd;
        reg_addr_t   rs1;
        reg_addr_t   stride;
        logic [10:0] offset;
        logic [6:0]  opcode;
    } m_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        m_fmt_t m_fmt;
    } instr_u;

    typedef struct packed {
        logic        halt;
        logic        i_flag;
        logic        s_reg_write;
        logic        m_reg_write;
        logic        jal;
        logic        jalr;
        aluop_t      alu_op;
        branch_t     branch_op;
        scalar_mem_t s_mem_type;
        matrix_mem_t m_mem_type;
        fu_scalar_t  fu_s;
        fu_matrix_t  fu_m;
        fu_type_t    fu_t;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        mreg_addr_t  matrix_rd;
        reg_addr_t   stride;
        word_t       imm;
    } ctrl_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t rs1_val;
        word_t rs2_val;
        word_t stride_val;
    } issue_t;

endpackage

`default_nettype wire

/* hw/issue_stage.sv */
////////////////////////////////////////////////////////////
// issue register with stall hold and sticky halt
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module issue_stage
    import isa_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   instr_valid,
    input  logic   stall,
    input  ctrl_t  ctrl,
    input  word_t  rs1_data,
    input  word_t  rs2_data,
    input  word_t  rs3_data,
    output issue_t issue,
    output logic   issue_valid,
    output logic   halted
);

    logic   accept;
    issue_t next_issue;

    // nothing is taken while stalled or once halted
    assign accept = instr_valid && !stall && !halted;

    always_comb
    begin
        next_issue.ctrl       = ctrl;
        next_issue.rs1_val    = rs1_data;
        next_issue.rs2_val    = rs2_data;
        next_issue.stride_val = rs3_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            issue       <= '0;
            issue_valid <= 1'b0;
            halted      <= 1'b0;
        end
        else if (accept)
        begin
            issue       <= next_issue;
            issue_valid <= 1'b1;
            // the halt itself still issues
            if (ctrl.halt)
            begin
                halted <= 1'b1;
            end
        end
        else if (!stall)
        begin
            issue_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/scalar_regfile.sv */
////////////////////////////////////////////////////////////
// scalar register file with 3 read ports and write bypass
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module scalar_regfile
    import isa_pkg::*;
#(
    parameter int NUM_SREGS = 32
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wb_en,
    input  reg_addr_t wb_rd,
    input  word_t     wb_data,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rs3,
    output word_t     rs1_data,
    output word_t     rs2_data,
    output word_t     rs3_data
);

    localparam int AW = $clog2(NUM_SREGS);

    word_t regs [NUM_SREGS];
    logic  wr_ok;

    // x0 and indices past a small file are never written
    assign wr_ok = wb_en && (wb_rd != '0) && (int'(wb_rd) < NUM_SREGS);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            regs <= '{default: '0};
        end
        else if (wr_ok)
        begin
            regs[wb_rd[AW-1:0]] <= wb_data;
        end
    end

    function automatic word_t read_port(input reg_addr_t addr);
        word_t val;
        if (addr == '0 || int'(addr) >= NUM_SREGS)
            val = '0;
        else if (wb_en && wb_rd == addr)
            val = wb_data;
        else
            val = regs[addr[AW-1:0]];
        return val;
    endfunction

    // reads follow the array and the bypass inputs as well as the address
    always_comb
    begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
        // stride register for matrix memory ops
        rs3_data = read_port(rs3);
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/isa_pkg.sv
hw/control_unit.sv
hw/scalar_regfile.sv
hw/issue_stage.sv
hw/decode_top.sv
dv/tb_decode_top.sv
